// ==== common/pr_consts.svh ====
// Stream widths, buffer depths and storage word tag values
`ifndef PR_CONSTS_SVH
`define PR_CONSTS_SVH

// Stream fields
`define PR_DATA_W 64
`define PR_KEEP_W 8
`define PR_USER_W 16

// Storage word is data, keep and a tag byte on top
`define PR_TAG_W 8
`define PR_WORD_W 80

// Tag byte values
`define PR_TAG_HDR 8'h01
`define PR_TAG_LAST 8'h80
`define PR_TAG_DATA 8'h00

// Depth exponents
`define PR_FIFO_DEPTH_BITS 3
`define PR_MEM_DEPTH_BITS 6

// Replay pass count
`define PR_COUNT_W 8

`endif

// ==== common/pr_pkg.sv ====
// Shared types for the packet record and replay buffer
`include "pr_consts.svh"

package pr_pkg;

   // Header word holds tag 01 and the user field in the low bits
   // Data word holds tag, keep and data from top to bottom
   typedef logic [`PR_WORD_W-1:0] word_t;

   typedef logic [`PR_DATA_W-1:0] data_t;

   typedef logic [`PR_KEEP_W-1:0] keep_t;

   typedef logic [`PR_USER_W-1:0] user_t;

   // Word memory address
   typedef logic [`PR_MEM_DEPTH_BITS-1:0] mem_ptr_t;

   typedef logic [`PR_COUNT_W-1:0] count_t;

endpackage

// ==== hdl/fallthrough_fifo.sv ====
// Fall-through FIFO of storage words with a nearly-full flag
`timescale 1ns/1ps

module fallthrough_fifo #(
   parameter int DEPTH_BITS = 3
) (
   input  logic          clk,
   input  logic          resetn,
   input  pr_pkg::word_t din_i,
   input  logic          wr_en_i,
   input  logic          rd_en_i,
   output pr_pkg::word_t dout_o,
   output logic          empty_o,
   output logic          nearly_full_o
);

   localparam int DEPTH = 2 ** DEPTH_BITS;

   pr_pkg::word_t         mem [0:DEPTH-1];
   logic [DEPTH_BITS-1:0] wr_ptr_q;
   logic [DEPTH_BITS-1:0] rd_ptr_q;
   logic [DEPTH_BITS:0]   count_q;
   logic                  do_wr;
   logic                  do_rd;

   assign do_wr = wr_en_i && (count_q != (DEPTH_BITS + 1)'(DEPTH));
   assign do_rd = rd_en_i && !empty_o;

   // Head word is visible without a read cycle
   assign dout_o        = mem[rd_ptr_q];
   assign empty_o       = (count_q == '0);
   // Two free entries left for producers that look one cycle ahead
   assign nearly_full_o = (count_q >= (DEPTH_BITS + 1)'(DEPTH - 2));

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr_q] <= din_i;
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_rd) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

// ==== pack/pkt_packer.sv ====
// Packer FSM that turns stream packets into header and data storage words
`timescale 1ns/1ps
`include "pr_consts.svh"

module pkt_packer (
   input  logic          clk,
   input  logic          resetn,
   input  pr_pkg::data_t s_tdata_i,
   input  pr_pkg::keep_t s_tkeep_i,
   input  pr_pkg::user_t s_tuser_i,
   input  logic          s_tvalid_i,
   input  logic          s_tlast_i,
   output logic          s_tready_o,
   input  logic          fifo_nearly_full_i,
   output logic          fifo_wr_en_o,
   output pr_pkg::word_t fifo_din_o
);

   typedef enum logic {
      IDLE,
      SEND
   } state_t;

   state_t state_q;
   state_t state_d;
   logic   room;

   assign room = !fifo_nearly_full_i;

   always_comb begin
      state_d      = state_q;
      s_tready_o   = 1'b0;
      fifo_wr_en_o = s_tvalid_i && room;
      case (state_q)
         IDLE: begin
            // Header goes out first, the beat itself waits a cycle
            fifo_din_o = {`PR_TAG_HDR,
                          {(`PR_WORD_W - `PR_TAG_W - `PR_USER_W){1'b0}},
                          s_tuser_i};
            if (s_tvalid_i && room) begin
               state_d = SEND;
            end
         end
         default: begin
            fifo_din_o = {(s_tlast_i ? `PR_TAG_LAST : `PR_TAG_DATA), s_tkeep_i, s_tdata_i};
            s_tready_o = room;
            if (s_tvalid_i && room && s_tlast_i) begin
               state_d = IDLE;
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

endmodule

// ==== pack/pkt_unpacker.sv ====
// Unpacker FSM that turns storage words back into output stream beats
`timescale 1ns/1ps
`include "pr_consts.svh"

module pkt_unpacker (
   input  logic          clk,
   input  logic          resetn,
   input  pr_pkg::word_t fifo_dout_i,
   input  logic          fifo_empty_i,
   output logic          fifo_rd_en_o,
   output pr_pkg::data_t m_tdata_o,
   output pr_pkg::keep_t m_tkeep_o,
   output pr_pkg::user_t m_tuser_o,
   output logic          m_tvalid_o,
   output logic          m_tlast_o,
   input  logic          m_tready_i
);

   typedef enum logic {
      IDLE,
      SEND
   } state_t;

   state_t                state_q;
   state_t                state_d;
   pr_pkg::user_t         user_q;
   pr_pkg::user_t         user_d;
   logic [`PR_TAG_W-1:0]  tag;
   logic                  is_hdr;
   logic                  is_last;

   assign tag     = fifo_dout_i[`PR_WORD_W-1 -: `PR_TAG_W];
   assign is_hdr  = (tag == `PR_TAG_HDR);
   assign is_last = (tag == `PR_TAG_LAST);

   // Beat fields come straight from the FIFO head
   assign m_tdata_o = fifo_dout_i[`PR_DATA_W-1:0];
   assign m_tkeep_o = fifo_dout_i[`PR_DATA_W +: `PR_KEEP_W];
   assign m_tlast_o = is_last;
   assign m_tuser_o = user_q;

   always_comb begin
      state_d      = state_q;
      user_d       = user_q;
      m_tvalid_o   = 1'b0;
      fifo_rd_en_o = 1'b0;
      case (state_q)
         IDLE: begin
            // Stray data words left by an aborted replay are dropped here
            fifo_rd_en_o = !fifo_empty_i;
            if (!fifo_empty_i && is_hdr) begin
               user_d  = fifo_dout_i[`PR_USER_W-1:0];
               state_d = SEND;
            end
         end
         default: begin
            m_tvalid_o   = !fifo_empty_i;
            fifo_rd_en_o = m_tready_i && !fifo_empty_i;
            if (m_tready_i && !fifo_empty_i) begin
               // User field rides on the first beat only
               user_d = '0;
               if (is_last) begin
                  state_d = IDLE;
               end
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state_q <= IDLE;
         user_q  <= '0;
      end else begin
         state_q <= state_d;
         user_q  <= user_d;
      end
   end

endmodule

// ==== store/replay_store.sv ====
// Word memory that records packed words and replays them a counted number of times
`timescale 1ns/1ps
`include "pr_consts.svh"

module replay_store (
   input  logic           clk,
   input  logic           resetn,
   input  logic           sw_rst_i,
   input  logic           start_replay_i,
   input  pr_pkg::count_t replay_count_i,
   input  pr_pkg::word_t  rec_din_i,
   input  logic           rec_empty_i,
   output logic           rec_rd_en_o,
   input  logic           play_nearly_full_i,
   output logic           play_wr_en_o,
   output pr_pkg::word_t  play_dout_o,
   output logic           replay_busy_o
);

   pr_pkg::word_t    mem [0:2**`PR_MEM_DEPTH_BITS-1];
   pr_pkg::word_t    rd_data_q;
   pr_pkg::mem_ptr_t wr_ptr_q;
   pr_pkg::mem_ptr_t rd_ptr_q;
   pr_pkg::mem_ptr_t last_ptr;
   pr_pkg::count_t   passes_q;
   logic             mem_full_q;
   logic             busy_q;
   logic             issue_done_q;
   logic             rd_valid_q;
   logic             rd_last_q;
   logic             rec_empty;
   logic             start_ok;
   logic             rd_issue;
   logic             rd_wrap;

   // Record pointer doubles as the stored length, full flag covers 64
   assign rec_empty = (wr_ptr_q == '0) && !mem_full_q;
   assign last_ptr  = wr_ptr_q - 1'b1;

   assign rec_rd_en_o = !busy_q && !mem_full_q && !rec_empty_i && !sw_rst_i;

   assign start_ok = start_replay_i && !busy_q && !sw_rst_i &&
                     (replay_count_i != '0) && !rec_empty;
   assign rd_issue = busy_q && !issue_done_q && !play_nearly_full_i;
   assign rd_wrap  = (rd_ptr_q == last_ptr);

   // Read data only reaches the unpack FIFO during a replay
   assign play_wr_en_o  = rd_valid_q && busy_q;
   assign play_dout_o   = rd_data_q;
   assign replay_busy_o = busy_q;

   always_ff @(posedge clk) begin
      if (rec_rd_en_o) begin
         mem[wr_ptr_q] <= rec_din_i;
      end
      if (rd_issue) begin
         rd_data_q <= mem[rd_ptr_q];
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn || sw_rst_i) begin
         wr_ptr_q     <= '0;
         mem_full_q   <= 1'b0;
         rd_ptr_q     <= '0;
         passes_q     <= '0;
         busy_q       <= 1'b0;
         issue_done_q <= 1'b0;
         rd_valid_q   <= 1'b0;
         rd_last_q    <= 1'b0;
      end else begin
         if (rec_rd_en_o) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
            if (wr_ptr_q == '1) begin
               mem_full_q <= 1'b1;
            end
         end

         rd_valid_q <= rd_issue;
         rd_last_q  <= rd_issue && rd_wrap && (passes_q == pr_pkg::count_t'(1));

         if (start_ok) begin
            busy_q       <= 1'b1;
            issue_done_q <= 1'b0;
            rd_ptr_q     <= '0;
            passes_q     <= replay_count_i;
         end else if (rd_issue) begin
            if (rd_wrap) begin
               // End of one pass over the recording
               rd_ptr_q <= '0;
               passes_q <= passes_q - 1'b1;
               if (passes_q == pr_pkg::count_t'(1)) begin
                  issue_done_q <= 1'b1;
               end
            end else begin
               rd_ptr_q <= rd_ptr_q + 1'b1;
            end
         end

         // Busy drops once the final word has gone into the FIFO
         if (rd_valid_q && rd_last_q) begin
            busy_q <= 1'b0;
         end
      end
   end

endmodule

// ==== hdl/pkt_replay_top.sv ====
// Top level of the packet record and replay buffer
`timescale 1ns/1ps
`include "pr_consts.svh"

module pkt_replay_top (
   input  logic           clk,
   input  logic           resetn,
   input  pr_pkg::data_t  s_tdata_i,
   input  pr_pkg::keep_t  s_tkeep_i,
   input  pr_pkg::user_t  s_tuser_i,
   input  logic           s_tvalid_i,
   input  logic           s_tlast_i,
   output logic           s_tready_o,
   output pr_pkg::data_t  m_tdata_o,
   output pr_pkg::keep_t  m_tkeep_o,
   output pr_pkg::user_t  m_tuser_o,
   output logic           m_tvalid_o,
   output logic           m_tlast_o,
   input  logic           m_tready_i,
   input  logic           start_replay_i,
   input  pr_pkg::count_t replay_count_i,
   input  logic           sw_rst_i,
   output logic           replay_busy_o
);

   pr_pkg::word_t pack_din;
   pr_pkg::word_t pack_dout;
   logic          pack_wr_en;
   logic          pack_rd_en;
   logic          pack_empty;
   logic          pack_nearly_full;

   pr_pkg::word_t play_din;
   pr_pkg::word_t play_dout;
   logic          play_wr_en;
   logic          play_rd_en;
   logic          play_empty;
   logic          play_nearly_full;

   pkt_packer pkt_packer_i (
      .clk                (clk),
      .resetn             (resetn),
      .s_tdata_i          (s_tdata_i),
      .s_tkeep_i          (s_tkeep_i),
      .s_tuser_i          (s_tuser_i),
      .s_tvalid_i         (s_tvalid_i),
      .s_tlast_i          (s_tlast_i),
      .s_tready_o         (s_tready_o),
      .fifo_nearly_full_i (pack_nearly_full),
      .fifo_wr_en_o       (pack_wr_en),
      .fifo_din_o         (pack_din)
   );

   fallthrough_fifo #(
      .DEPTH_BITS (`PR_FIFO_DEPTH_BITS)
   ) pack_fifo (
      .clk           (clk),
      .resetn        (resetn),
      .din_i         (pack_din),
      .wr_en_i       (pack_wr_en),
      .rd_en_i       (pack_rd_en),
      .dout_o        (pack_dout),
      .empty_o       (pack_empty),
      .nearly_full_o (pack_nearly_full)
   );

   replay_store replay_store_i (
      .clk                (clk),
      .resetn             (resetn),
      .sw_rst_i           (sw_rst_i),
      .start_replay_i     (start_replay_i),
      .replay_count_i     (replay_count_i),
      .rec_din_i          (pack_dout),
      .rec_empty_i        (pack_empty),
      .rec_rd_en_o        (pack_rd_en),
      .play_nearly_full_i (play_nearly_full),
      .play_wr_en_o       (play_wr_en),
      .play_dout_o        (play_din),
      .replay_busy_o      (replay_busy_o)
   );

   fallthrough_fifo #(
      .DEPTH_BITS (`PR_FIFO_DEPTH_BITS)
   ) play_fifo (
      .clk           (clk),
      .resetn        (resetn),
      .din_i         (play_din),
      .wr_en_i       (play_wr_en),
      .rd_en_i       (play_rd_en),
      .dout_o        (play_dout),
      .empty_o       (play_empty),
      .nearly_full_o (play_nearly_full)
   );

   pkt_unpacker pkt_unpacker_i (
      .clk          (clk),
      .resetn       (resetn),
      .fifo_dout_i  (play_dout),
      .fifo_empty_i (play_empty),
      .fifo_rd_en_o (play_rd_en),
      .m_tdata_o    (m_tdata_o),
      .m_tkeep_o    (m_tkeep_o),
      .m_tuser_o    (m_tuser_o),
      .m_tvalid_o   (m_tvalid_o),
      .m_tlast_o    (m_tlast_o),
      .m_tready_i   (m_tready_i)
   );

endmodule

// ==== bench/tb_pkt_replay.sv ====
// Testbench with clock, reset, packet stimulus, reference queue and output checks
`timescale 1ns/1ps
`include "pr_consts.svh"

module tb_pkt_replay;

   localparam int BEAT_W  = `PR_USER_W + 1 + `PR_KEEP_W + `PR_DATA_W;
   localparam int TIMEOUT = 2000;

   logic                  clk;
   logic                  resetn;
   logic [`PR_DATA_W-1:0] s_tdata_i;
   logic [`PR_KEEP_W-1:0] s_tkeep_i;
   logic [`PR_USER_W-1:0] s_tuser_i;
   logic                  s_tvalid_i;
   logic                  s_tlast_i;
   logic                  s_tready_o;
   logic [`PR_DATA_W-1:0] m_tdata_o;
   logic [`PR_KEEP_W-1:0] m_tkeep_o;
   logic [`PR_USER_W-1:0] m_tuser_o;
   logic                  m_tvalid_o;
   logic                  m_tlast_o;
   logic                  m_tready_i;
   logic                  start_replay_i;
   pr_pkg::count_t        replay_count_i;
   logic                  sw_rst_i;
   logic                  replay_busy_o;

   // Beats are {user, last, keep, data}
   logic [BEAT_W-1:0] rec_q [$];
   logic [BEAT_W-1:0] exp_q [$];
   logic [BEAT_W-1:0] stall_beat;
   logic [31:0]       lfsr_q;
   logic              random_ready;
   logic              stall_q;
   int                errors;
   int                checks;
   int                tests;
   int                test_start_errors;

   pkt_replay_top pkt_replay_top_i (
      .clk            (clk),
      .resetn         (resetn),
      .s_tdata_i      (s_tdata_i),
      .s_tkeep_i      (s_tkeep_i),
      .s_tuser_i      (s_tuser_i),
      .s_tvalid_i     (s_tvalid_i),
      .s_tlast_i      (s_tlast_i),
      .s_tready_o     (s_tready_o),
      .m_tdata_o      (m_tdata_o),
      .m_tkeep_o      (m_tkeep_o),
      .m_tuser_o      (m_tuser_o),
      .m_tvalid_o     (m_tvalid_o),
      .m_tlast_o      (m_tlast_o),
      .m_tready_i     (m_tready_i),
      .start_replay_i (start_replay_i),
      .replay_count_i (replay_count_i),
      .sw_rst_i       (sw_rst_i),
      .replay_busy_o  (replay_busy_o)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Taps 32, 22, 2, 1
   function automatic logic next_bit();
      logic fb;
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      return fb;
   endfunction

   function automatic logic [63:0] take_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[62:0], next_bit()};
      end
      return v;
   endfunction

   task automatic check_field(input string name, input logic [63:0] got,
                              input logic [63:0] want);
      checks++;
      field_match: assert (got == want) else begin
         $display("ERROR %s got %h expected %h", name, got, want);
         errors++;
      end
   endtask

   task automatic compare_beat(input logic [BEAT_W-1:0] got, input logic [BEAT_W-1:0] want);
      check_field("m_tdata_o", 64'(got[`PR_DATA_W-1:0]), 64'(want[`PR_DATA_W-1:0]));
      check_field("m_tkeep_o", 64'(got[`PR_DATA_W +: `PR_KEEP_W]),
                  64'(want[`PR_DATA_W +: `PR_KEEP_W]));
      check_field("m_tlast_o", 64'(got[BEAT_W-`PR_USER_W-1]), 64'(want[BEAT_W-`PR_USER_W-1]));
      check_field("m_tuser_o", 64'(got[BEAT_W-1 -: `PR_USER_W]),
                  64'(want[BEAT_W-1 -: `PR_USER_W]));
   endtask

   // Output monitor compares each beat that the next rising edge accepts
   always @(negedge clk) begin
      logic [BEAT_W-1:0] got;
      logic [BEAT_W-1:0] want;
      got = {m_tuser_o, m_tlast_o, m_tkeep_o, m_tdata_o};
      if (!resetn) begin
         stall_q = 1'b0;
      end else begin
         if (stall_q) begin
            check_field("m_tvalid_o", 64'(m_tvalid_o), 64'd1);
            compare_beat(got, stall_beat);
         end
         if (m_tvalid_o && m_tready_i) begin
            if (exp_q.size() == 0) begin
               $display("Output beat with data %h appeared when none was due", m_tdata_o);
               errors++;
            end else begin
               want = exp_q.pop_front();
               compare_beat(got, want);
            end
         end
         stall_q    = m_tvalid_o && !m_tready_i;
         stall_beat = got;
      end
   end

   always @(posedge clk) begin
      if (random_ready) begin
         m_tready_i <= next_bit();
      end else begin
         m_tready_i <= 1'b1;
      end
   end

   task automatic send_packet(input int beats);
      logic [63:0]           r;
      logic [`PR_USER_W-1:0] user;
      logic [`PR_USER_W-1:0] beat_user;
      logic [`PR_KEEP_W-1:0] keep;
      logic [`PR_DATA_W-1:0] data;
      logic                  last;
      int                    n;
      @(posedge clk);
      r    = take_bits(`PR_USER_W);
      user = r[`PR_USER_W-1:0];
      for (int i = 0; i < beats; i++) begin
         data      = take_bits(`PR_DATA_W);
         r         = take_bits(`PR_KEEP_W);
         keep      = r[`PR_KEEP_W-1:0];
         last      = (i == beats - 1);
         beat_user = (i == 0) ? user : '0;
         rec_q.push_back({beat_user, last, keep, data});
         s_tdata_i  <= data;
         s_tkeep_i  <= keep;
         s_tuser_i  <= user;
         s_tlast_i  <= last;
         s_tvalid_i <= 1'b1;
         n = 0;
         @(negedge clk);
         while (!s_tready_o && n < TIMEOUT) begin
            @(negedge clk);
            n++;
         end
         if (!s_tready_o) begin
            $display("Input beat %0d was not accepted within %0d cycles", i, TIMEOUT);
            errors++;
         end
         @(posedge clk);
      end
      s_tvalid_i <= 1'b0;
      s_tlast_i  <= 1'b0;
   endtask

   task automatic send_random_packets(input int count);
      logic [63:0] r;
      for (int p = 0; p < count; p++) begin
         r = take_bits(2);
         send_packet(int'(r[1:0]) + 1);
      end
   endtask

   // Pack FIFO empty means every word has reached the memory
   task automatic wait_recorded();
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!pkt_replay_top_i.pack_empty && n < TIMEOUT);
      if (!pkt_replay_top_i.pack_empty) begin
         $display("Recording did not finish within %0d cycles", TIMEOUT);
         errors++;
      end
   endtask

   task automatic wait_busy(input logic level);
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (replay_busy_o != level && n < TIMEOUT);
      if (replay_busy_o != level) begin
         $display("replay_busy_o did not reach %0b within %0d cycles", level, TIMEOUT);
         errors++;
      end
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (exp_q.size() != 0 && n < TIMEOUT);
      if (exp_q.size() != 0) begin
         $display("Output stopped with %0d expected beats missing", exp_q.size());
         errors++;
         exp_q.delete();
      end
      @(posedge clk);
   endtask

   task automatic start_replay(input int passes);
      for (int p = 0; p < passes; p++) begin
         foreach (rec_q[i]) begin
            exp_q.push_back(rec_q[i]);
         end
      end
      @(posedge clk);
      start_replay_i <= 1'b1;
      replay_count_i <= pr_pkg::count_t'(passes);
      @(posedge clk);
      start_replay_i <= 1'b0;
   endtask

   task automatic run_replay(input int passes);
      start_replay(passes);
      wait_busy(1'b1);
      wait_busy(1'b0);
      wait_drained();
   endtask

   task automatic finish_test(input string name);
      tests++;
      $display("Test %0d %s finished with %0d errors", tests, name, errors - test_start_errors);
      test_start_errors = errors;
   endtask

   initial begin
      lfsr_q            = 32'h91a4;
      resetn            = 1'b0;
      s_tdata_i         = '0;
      s_tkeep_i         = '0;
      s_tuser_i         = '0;
      s_tvalid_i        = 1'b0;
      s_tlast_i         = 1'b0;
      m_tready_i        = 1'b1;
      start_replay_i    = 1'b0;
      replay_count_i    = '0;
      sw_rst_i          = 1'b0;
      random_ready      = 1'b0;
      stall_q           = 1'b0;
      errors            = 0;
      checks            = 0;
      tests             = 0;
      test_start_errors = 0;

      repeat (16) @(posedge clk);
      resetn <= 1'b1;
      @(posedge clk);
      @(negedge clk);
      check_field("m_tvalid_o", 64'(m_tvalid_o), 64'd0);
      check_field("s_tready_o", 64'(s_tready_o), 64'd0);
      check_field("replay_busy_o", 64'(replay_busy_o), 64'd0);
      finish_test("after reset");

      // Monitor flags any beat here since nothing is expected yet
      send_random_packets(3);
      wait_recorded();
      run_replay(1);
      finish_test("single replay");

      start_replay(3);
      wait_busy(1'b1);
      wait_busy(1'b0);
      @(negedge clk);
      busy_after_last_pass: assert (exp_q.size() <= 2 ** `PR_FIFO_DEPTH_BITS) else begin
         $display("replay_busy_o fell with %0d beats still due", exp_q.size());
         errors++;
      end
      wait_drained();
      finish_test("counted replay");

      send_random_packets(2);
      wait_recorded();
      random_ready <= 1'b1;
      run_replay(2);
      random_ready <= 1'b0;
      finish_test("output back-pressure");

      sw_rst_i <= 1'b1;
      @(posedge clk);
      sw_rst_i <= 1'b0;
      rec_q.delete();
      start_replay(1);
      repeat (20) begin
         @(negedge clk);
         check_field("replay_busy_o", 64'(replay_busy_o), 64'd0);
      end
      send_packet(3);
      wait_recorded();
      run_replay(1);
      finish_test("software clear");

      $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+common
common/pr_pkg.sv
hdl/fallthrough_fifo.sv
pack/pkt_packer.sv
pack/pkt_unpacker.sv
store/replay_store.sv
hdl/pkt_replay_top.sv
bench/tb_pkt_replay.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_pkt_replay
FILELIST = build.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
